// File: Bender.yml
package:
  name: soc_periph

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/soc_pkg.sv
      - hw/bus_decoder.sv
      - hw/soc_ram.sv
      - hw/soc_timer.sv
      - hw/uart_tx.sv
      - hw/soc_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_soc_top.sv

// File: bench/tb_clock_gen.sv
/* Testbench clock and reset
   Free-running clock with an active-low reset held for a few cycles */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release just after a rising edge, like the other DUT inputs
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

endmodule

// File: bench/tb_soc_top.sv
/* Testbench for the peripheral subsystem
   Table-driven bus transfers against RAM, timer, UART and unmapped space */
`timescale 1ns/1ps
`include "soc_defs.svh"

module tb_soc_top import soc_pkg::*; ();

    localparam int CLKS         = `SOC_UART_CLKS_PER_BIT;
    localparam int TMR_LOAD_VAL = 20;

    typedef struct {
        logic      write;
        bus_addr_t addr;
        bus_strb_t strb;
        bus_data_t wdata;
        bus_data_t exp_rdata;
        logic      check;
    } entry_t;

    logic       clk;
    logic       arst_n;
    logic       valid   = 1'b0;
    bus_addr_t  address = '0;
    bus_strb_t  wstrobe = '0;
    bus_data_t  wdata   = '0;
    logic       ready;
    bus_data_t  rdata;
    logic       irq;
    logic       uart_tx;

    entry_t     stim[$];
    bus_data_t  ref_mem [`SOC_RAM_WORDS];
    logic [7:0] tx_bytes [2];
    logic [7:0] rx_bytes [2];
    int         phase_end [5];
    integer     seed        = 55688;
    int         error_count = 0;
    int         check_count = 0;
    int         cycle_count = 0;
    int         cycle_limit = 0;
    int         frames_rx   = 0;

    tb_clock_gen #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (3)
    ) u_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    soc_top u_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .valid   (valid),
        .address (address),
        .wstrobe (wstrobe),
        .wdata   (wdata),
        .ready   (ready),
        .rdata   (rdata),
        .irq     (irq),
        .uart_tx (uart_tx)
    );

    task automatic check_value(input string name, input bus_data_t actual,
                               input bus_data_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    function automatic bus_addr_t dev_addr(logic [7:0] dev, logic [7:0] offset);
        return {dev, 16'h0000, offset};
    endfunction

    function automatic bus_data_t merge_bytes(bus_data_t old_word, bus_data_t new_word,
                                              bus_strb_t strb);
        bus_data_t res;
        res = old_word;
        for (int lane = 0; lane < 4; lane++) begin
            if (strb[lane]) begin
                res[lane*8 +: 8] = new_word[lane*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic void add_entry(logic wr, bus_addr_t addr, bus_strb_t strb,
                                      bus_data_t wd, bus_data_t exp, logic chk);
        entry_t e;
        e = '{wr, addr, strb, wd, exp, chk};
        stim.push_back(e);
    endfunction

    task automatic build_table();
        bus_addr_t ram_addr [8];
        bus_addr_t alias_addr;
        bus_data_t word;
        bus_strb_t strb;
        int        idx;
        // Full words at random addresses
        for (int i = 0; i < 8; i++) begin
            ram_addr[i] = {8'h00, 22'($random(seed)), 2'b00};
            word = $random(seed);
            idx = ram_addr[i][31:2] % `SOC_RAM_WORDS;
            ref_mem[idx] = word;
            add_entry(1'b1, ram_addr[i], 4'hF, word, '0, 1'b0);
        end
        // Read back through an alias with another upper address bit
        for (int i = 0; i < 8; i++) begin
            alias_addr = ram_addr[i] ^ 32'h0000_0400;
            idx = alias_addr[31:2] % `SOC_RAM_WORDS;
            add_entry(1'b0, alias_addr, '0, '0, ref_mem[idx], 1'b1);
        end
        // Partial strobes merge into the words already there
        for (int i = 0; i < 4; i++) begin
            strb = 4'($random(seed));
            if (strb == 4'h0 || strb == 4'hF) begin
                strb = 4'b0110;
            end
            word = $random(seed);
            idx = ram_addr[i][31:2] % `SOC_RAM_WORDS;
            ref_mem[idx] = merge_bytes(ref_mem[idx], word, strb);
            add_entry(1'b1, ram_addr[i], strb, word, '0, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            idx = ram_addr[i][31:2] % `SOC_RAM_WORDS;
            add_entry(1'b0, ram_addr[i], '0, '0, ref_mem[idx], 1'b1);
        end
        add_entry(1'b0, 32'h4200_0010, '0, '0, '0, 1'b1);
        phase_end[0] = stim.size();

        add_entry(1'b1, dev_addr(`SOC_DEV_TIMER, `SOC_TMR_LOAD), 4'hF, TMR_LOAD_VAL, '0, 1'b0);
        add_entry(1'b1, dev_addr(`SOC_DEV_TIMER, `SOC_TMR_CTRL), 4'hF, 32'd1, '0, 1'b0);
        add_entry(1'b0, dev_addr(`SOC_DEV_TIMER, `SOC_TMR_LOAD), '0, '0, TMR_LOAD_VAL, 1'b1);
        phase_end[1] = stim.size();

        // Once irq is up
        add_entry(1'b0, dev_addr(`SOC_DEV_TIMER, `SOC_TMR_PEND), '0, '0, 32'd1, 1'b1);
        add_entry(1'b1, dev_addr(`SOC_DEV_TIMER, `SOC_TMR_PEND), 4'hF, 32'd1, '0, 1'b0);
        add_entry(1'b0, dev_addr(`SOC_DEV_TIMER, `SOC_TMR_PEND), '0, '0, 32'd0, 1'b1);
        add_entry(1'b1, dev_addr(`SOC_DEV_TIMER, `SOC_TMR_CTRL), 4'hF, 32'd0, '0, 1'b0);
        phase_end[2] = stim.size();

        // Second DATA write stalls until the first frame is out
        for (int i = 0; i < 2; i++) begin
            tx_bytes[i] = 8'($random(seed));
            word = {24'($random(seed)), tx_bytes[i]};
            add_entry(1'b1, dev_addr(`SOC_DEV_UART, `SOC_UART_DATA), 4'b0001, word, '0, 1'b0);
        end
        add_entry(1'b0, dev_addr(`SOC_DEV_UART, `SOC_UART_STAT), '0, '0, 32'd1, 1'b1);
        phase_end[3] = stim.size();
        add_entry(1'b0, dev_addr(`SOC_DEV_UART, `SOC_UART_STAT), '0, '0, 32'd0, 1'b1);
        phase_end[4] = stim.size();

        cycle_limit = stim.size() * 4 + 2 * 12 * CLKS + 200;
    endtask

    // Starts and ends 1 ns after a rising edge
    task automatic run_entries(input int first, input int last);
        entry_t    e;
        bus_data_t got;
        bit        done;
        for (int i = first; i < last; i++) begin
            e = stim[i];
            valid   = 1'b1;
            address = e.addr;
            wstrobe = e.write ? e.strb : '0;
            wdata   = e.wdata;
            done    = 1'b0;
            while (!done) begin
                // Sampled on the falling edge while stable
                @(negedge clk);
                if (ready) begin
                    got  = rdata;
                    done = 1'b1;
                end
                @(posedge clk);
                #1;
            end
            if (e.check) begin
                check_value($sformatf("rdata entry %0d @0x%08h", i, e.addr), got, e.exp_rdata);
            end
        end
        valid   = 1'b0;
        wstrobe = '0;
    endtask

    // UART line decoder sampling mid-bit on falling edges
    initial begin : line_decoder
        logic [7:0] rx_shift;
        wait (arst_n === 1'b1);
        for (int f = 0; f < 2; f++) begin
            do begin
                @(negedge clk);
            end while (uart_tx !== 1'b0);
            repeat (CLKS / 2) @(negedge clk);
            check_value("uart_tx start bit", uart_tx, 1'b0);
            for (int b = 0; b < 8; b++) begin
                repeat (CLKS) @(negedge clk);
                rx_shift[b] = uart_tx;
            end
            repeat (CLKS) @(negedge clk);
            check_value("uart_tx stop bit", uart_tx, 1'b1);
            // Rest of the stop bit
            repeat (CLKS / 2) @(negedge clk);
            rx_bytes[f] = rx_shift;
            frames_rx++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles", cycle_count);
            $display("Checks: %0d, errors: %0d", check_count, error_count + 1);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin : main_seq
        uart_state_e tx_state;
        int          wait_cycles;
        build_table();
        wait (arst_n === 1'b1);
        @(posedge clk);
        #1;
        check_value("ready", ready, 1'b0);
        check_value("irq", irq, 1'b0);
        check_value("uart_tx", uart_tx, 1'b1);

        run_entries(0, phase_end[0]);
        run_entries(phase_end[0], phase_end[1]);
        wait_cycles = 0;
        while (irq !== 1'b1 && wait_cycles < 4 * (TMR_LOAD_VAL + 1)) begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end
        if (irq !== 1'b1) begin
            error_count++;
            $display("Timer irq never rose within %0d cycles", wait_cycles);
        end
        run_entries(phase_end[1], phase_end[2]);
        check_value("irq", irq, 1'b0);

        run_entries(phase_end[2], phase_end[3]);
        wait_cycles = 0;
        while (frames_rx < 2 && wait_cycles < 2 * 12 * CLKS) begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end
        if (frames_rx < 2) begin
            error_count++;
            tx_state = u_dut.u_uart.state_q;
            $display("Only %0d of 2 UART frames seen, transmitter in %s",
                     frames_rx, tx_state.name());
        end else begin
            check_value("uart byte 0", rx_bytes[0], tx_bytes[0]);
            check_value("uart byte 1", rx_bytes[1], tx_bytes[1]);
        end
        run_entries(phase_end[3], phase_end[4]);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+hw
hw/soc_pkg.sv
hw/bus_decoder.sv
hw/soc_ram.sv
hw/soc_timer.sv
hw/uart_tx.sv
hw/soc_top.sv
bench/tb_clock_gen.sv
bench/tb_soc_top.sv

// File: hw/bus_decoder.sv
/* Bus decoder
   Routes valid to one device by address byte and muxes ready and rdata back */
`timescale 1ns/1ps
`include "soc_defs.svh"

module bus_decoder import soc_pkg::*; (
    input  logic      valid,
    input  bus_addr_t address,

    output logic      ram_valid,
    output logic      timer_valid,
    output logic      uart_valid,

    input  logic      ram_ready,
    input  logic      timer_ready,
    input  logic      uart_ready,
    input  bus_data_t ram_rdata,
    input  bus_data_t timer_rdata,
    input  bus_data_t uart_rdata,

    output logic      ready,
    output bus_data_t rdata
);

    logic [7:0] dev_byte;
    dev_sel_e   dev_sel;

    assign dev_byte = address[31:24];

    always_comb begin
        case (dev_byte)
            `SOC_DEV_RAM:   dev_sel = DEV_RAM;
            `SOC_DEV_TIMER: dev_sel = DEV_TIMER;
            `SOC_DEV_UART:  dev_sel = DEV_UART;
            default:        dev_sel = DEV_NONE;
        endcase
    end

    assign ram_valid   = valid && (dev_sel == DEV_RAM);
    assign timer_valid = valid && (dev_sel == DEV_TIMER);
    assign uart_valid  = valid && (dev_sel == DEV_UART);

    always_comb begin
        case (dev_sel)
            DEV_RAM: begin
                ready = ram_ready;
                rdata = ram_rdata;
            end
            DEV_TIMER: begin
                ready = timer_ready;
                rdata = timer_rdata;
            end
            DEV_UART: begin
                ready = uart_ready;
                rdata = uart_rdata;
            end
            default: begin
                // Unmapped space completes at once and reads zero
                ready = valid;
                rdata = '0;
            end
        endcase
    end

endmodule

// File: hw/soc_defs.svh
/* SoC constants for the peripheral subsystem
   Device address map, RAM depth, UART bit timing and register offsets */
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// Device byte, held in address bits 31 to 24
`define SOC_DEV_RAM           8'h00
`define SOC_DEV_TIMER         8'h80
`define SOC_DEV_UART          8'h81

// RAM depth in 32-bit words
`define SOC_RAM_WORDS         256

// Clock cycles per transmitted UART bit
`define SOC_UART_CLKS_PER_BIT 8

// Timer register offsets
`define SOC_TMR_LOAD          8'h00
`define SOC_TMR_CTRL          8'h04
`define SOC_TMR_PEND          8'h08
`define SOC_TMR_COUNT         8'h0C

// UART register offsets
`define SOC_UART_DATA         8'h00
`define SOC_UART_STAT         8'h04

`endif

// File: hw/soc_pkg.sv
/* Shared types of the peripheral subsystem
   Bus word types, device select and UART transmitter states */
package soc_pkg;

    // One bus word of address, data and byte strobes
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;

    // Any strobe bit set marks a write
    typedef logic [3:0]  bus_strb_t;

    // Device picked by the top address byte
    typedef enum logic [1:0] {
        DEV_RAM,
        DEV_TIMER,
        DEV_UART,
        DEV_NONE
    } dev_sel_e;

    // Frame phases of the UART transmitter
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

endpackage

// File: hw/soc_ram.sv
/* Single-port word RAM
   Byte write strobes, one wait state per access */
`timescale 1ns/1ps
`include "soc_defs.svh"

module soc_ram import soc_pkg::*; #(
    parameter int SIZE_WORDS = `SOC_RAM_WORDS
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      valid,
    input  bus_addr_t address,
    input  bus_strb_t wstrobe,
    input  bus_data_t wdata,
    output logic      ready,
    output bus_data_t rdata
);

    localparam int IDX_W = $clog2(SIZE_WORDS);

    bus_data_t        mem [SIZE_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic             ack_q;
    bus_data_t        rdata_q;

    // Word index wraps at the RAM depth
    assign word_idx = IDX_W'(address[31:2] % SIZE_WORDS);

    // Acknowledge one cycle after valid, then drop for a cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= valid && !ack_q;
        end
    end

    // Old word is latched in the wait cycle, strobed lanes written on ack
    always_ff @(posedge clk) begin
        if (valid && !ack_q) begin
            rdata_q <= mem[word_idx];
        end
        if (valid && ack_q) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wstrobe[lane]) begin
                    mem[word_idx][lane*8 +: 8] <= wdata[lane*8 +: 8];
                end
            end
        end
    end

    assign ready = ack_q;
    assign rdata = rdata_q;

endmodule

// File: hw/soc_timer.sv
/* Down-counting timer
   Reloads from LOAD on reaching zero and flags PEND, which drives irq */
`timescale 1ns/1ps
`include "soc_defs.svh"

module soc_timer import soc_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      valid,
    input  bus_addr_t address,
    input  bus_strb_t wstrobe,
    input  bus_data_t wdata,
    output logic      ready,
    output bus_data_t rdata,
    output logic      irq
);

    logic [7:0] offset;
    logic       wr_en;
    logic       expired;
    bus_data_t  load_q;
    bus_data_t  count_q;
    logic       ctrl_en_q;
    logic       pend_q;

    assign offset  = address[7:0];
    assign wr_en   = valid && (wstrobe != '0);
    assign expired = ctrl_en_q && (count_q == '0);

    // Register file and counter
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_q    <= '0;
            count_q   <= '0;
            ctrl_en_q <= 1'b0;
        end else begin
            if (wr_en && offset == `SOC_TMR_LOAD) begin
                load_q  <= wdata;
                count_q <= wdata;
            end else if (expired) begin
                count_q <= load_q;
            end else if (ctrl_en_q) begin
                count_q <= count_q - 1'b1;
            end
            if (wr_en && offset == `SOC_TMR_CTRL) begin
                ctrl_en_q <= wdata[0];
            end
        end
    end

    // A new expiry wins over a clear in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_q <= 1'b0;
        end else if (expired) begin
            pend_q <= 1'b1;
        end else if (wr_en && offset == `SOC_TMR_PEND && wdata[0]) begin
            pend_q <= 1'b0;
        end
    end

    always_comb begin
        case (offset)
            `SOC_TMR_LOAD:  rdata = load_q;
            `SOC_TMR_CTRL:  rdata = {31'b0, ctrl_en_q};
            `SOC_TMR_PEND:  rdata = {31'b0, pend_q};
            `SOC_TMR_COUNT: rdata = count_q;
            default:        rdata = '0;
        endcase
    end

    // Registers answer in the same cycle
    assign ready = valid;
    assign irq   = pend_q;

endmodule

// File: hw/soc_top.sv
/* Peripheral subsystem top
   Bus decoder with RAM, timer and transmit-only UART behind it */
`timescale 1ns/1ps
`include "soc_defs.svh"

module soc_top import soc_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      valid,
    input  bus_addr_t address,
    input  bus_strb_t wstrobe,
    input  bus_data_t wdata,
    output logic      ready,
    output bus_data_t rdata,
    output logic      irq,
    output logic      uart_tx
);

    logic      ram_valid;
    logic      timer_valid;
    logic      uart_valid;
    logic      ram_ready;
    logic      timer_ready;
    logic      uart_ready;
    bus_data_t ram_rdata;
    bus_data_t timer_rdata;
    bus_data_t uart_rdata;

    bus_decoder u_decoder (
        .valid       (valid),
        .address     (address),
        .ram_valid   (ram_valid),
        .timer_valid (timer_valid),
        .uart_valid  (uart_valid),
        .ram_ready   (ram_ready),
        .timer_ready (timer_ready),
        .uart_ready  (uart_ready),
        .ram_rdata   (ram_rdata),
        .timer_rdata (timer_rdata),
        .uart_rdata  (uart_rdata),
        .ready       (ready),
        .rdata       (rdata)
    );

    // Address, strobes and write data are shared by all devices
    soc_ram #(
        .SIZE_WORDS (`SOC_RAM_WORDS)
    ) u_ram (
        .clk     (clk),
        .arst_n  (arst_n),
        .valid   (ram_valid),
        .address (address),
        .wstrobe (wstrobe),
        .wdata   (wdata),
        .ready   (ram_ready),
        .rdata   (ram_rdata)
    );

    soc_timer u_timer (
        .clk     (clk),
        .arst_n  (arst_n),
        .valid   (timer_valid),
        .address (address),
        .wstrobe (wstrobe),
        .wdata   (wdata),
        .ready   (timer_ready),
        .rdata   (timer_rdata),
        .irq     (irq)
    );

    uart_tx u_uart (
        .clk     (clk),
        .arst_n  (arst_n),
        .valid   (uart_valid),
        .address (address),
        .wstrobe (wstrobe),
        .wdata   (wdata),
        .ready   (uart_ready),
        .rdata   (uart_rdata),
        .tx      (uart_tx)
    );

endmodule

// File: hw/uart_tx.sv
/* Bus-mapped UART transmitter
   Sends 8N1 frames LSB first, stalls DATA writes while a frame is out */
`timescale 1ns/1ps
`include "soc_defs.svh"

module uart_tx import soc_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      valid,
    input  bus_addr_t address,
    input  bus_strb_t wstrobe,
    input  bus_data_t wdata,
    output logic      ready,
    output bus_data_t rdata,
    output logic      tx
);

    localparam int CLKS  = `SOC_UART_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);

    uart_state_e      state_q;
    logic [CNT_W-1:0] bit_cnt_q;
    logic [2:0]       bit_idx_q;
    logic [7:0]       shift_q;
    logic             tx_q;
    logic [7:0]       offset;
    logic             busy;
    logic             data_write;
    logic             start;
    logic             bit_done;

    assign offset     = address[7:0];
    assign busy       = (state_q != UART_IDLE);
    assign data_write = (offset == `SOC_UART_DATA) && (wstrobe != '0);
    assign start      = valid && data_write && !busy;
    assign bit_done   = busy && (bit_cnt_q == CNT_W'(CLKS - 1));

    // Bit period counter, restarts at each bit boundary
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt_q <= '0;
        end else if (!busy || bit_done) begin
            bit_cnt_q <= '0;
        end else begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
        end
    end

    // Frame FSM, tx is registered to keep the line clean
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= UART_IDLE;
            bit_idx_q <= '0;
            tx_q      <= 1'b1;
        end else begin
            case (state_q)
                UART_IDLE: begin
                    if (start) begin
                        state_q <= UART_START;
                        tx_q    <= 1'b0;
                    end
                end
                UART_START: begin
                    if (bit_done) begin
                        state_q   <= UART_DATA;
                        bit_idx_q <= '0;
                        tx_q      <= shift_q[0];
                    end
                end
                UART_DATA: begin
                    if (bit_done) begin
                        if (bit_idx_q == 3'd7) begin
                            state_q <= UART_STOP;
                            tx_q    <= 1'b1;
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                            tx_q      <= shift_q[1];
                        end
                    end
                end
                default: begin
                    // Stop bit holds the line high
                    if (bit_done) begin
                        state_q <= UART_IDLE;
                    end
                end
            endcase
        end
    end

    // Payload byte, shifted at the end of each data bit
    always_ff @(posedge clk) begin
        if (start) begin
            shift_q <= wdata[7:0];
        end else if (state_q == UART_DATA && bit_done) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_comb begin
        if (offset == `SOC_UART_STAT) begin
            rdata = {31'b0, busy};
        end else begin
            rdata = '0;
        end
    end

    // Back-pressure on DATA writes until the frame ends
    assign ready = valid && !(data_write && busy);
    assign tx    = tx_q;

endmodule
